// File: soc_defs.svh
// ################################################
// Width, depth and count macros for the GPU SoC
// ################################################

`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Data width shared by every bus
`define SOC_DATA_W 32

// Byte address width
`define SOC_ADDR_W 10

// Memory depth in words
`define SOC_MEM_WORDS 256

// Requesters on the memory arbiter, fetch/data/control
`define SOC_NUM_REQ 3

// Compute clusters served by the scheduler
`define SOC_NUM_CLUSTERS 4

// Warp allocation fields
`define SOC_PC_W 16
`define SOC_TBLOCK_W 8
`define SOC_TGROUP_W 8

`endif

// File: soc_pkg.sv
// ################################################
// Shared vector types, bus structs and FSM states
// ################################################

`include "soc_defs.svh"

package soc_pkg;

    // ################################################
    // Plain vectors
    // ################################################
    typedef logic [`SOC_ADDR_W-1:0]       addr_t;
    typedef logic [`SOC_DATA_W-1:0]       data_t;
    typedef logic [`SOC_DATA_W/8-1:0]     sel_t;
    typedef logic [`SOC_PC_W-1:0]         pc_t;
    typedef logic [`SOC_TBLOCK_W-1:0]     tblock_idx_t;
    typedef logic [`SOC_TGROUP_W-1:0]     tgroup_id_t;
    typedef logic [`SOC_NUM_CLUSTERS-1:0] cluster_vec_t;
    typedef logic [`SOC_NUM_REQ-1:0]      req_vec_t;

    // ################################################
    // Wishbone classic
    // ################################################

    // Master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        sel_t  sel;
        data_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    // Read-only instruction fetch request
    typedef struct packed {
        logic  cyc;
        logic  stb;
        addr_t adr;
    } fetch_req_t;

    // Warp allocation handed to a cluster
    typedef struct packed {
        pc_t         pc;
        addr_t       dp_addr;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } alloc_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

endpackage

// File: mem_arbiter.sv
// ################################################
// Round-robin Wishbone arbiter, three requesters
// onto one memory port
// ################################################

`timescale 1ns/1ns

`include "soc_defs.svh"

module mem_arbiter (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    // Requester side, index 0 is fetch
    input  soc_pkg::wb_req_t [`SOC_NUM_REQ-1:0] req_i,
    output soc_pkg::wb_rsp_t [`SOC_NUM_REQ-1:0] rsp_o,

    // Memory side
    output soc_pkg::wb_req_t                    mem_req_o,
    input  soc_pkg::wb_rsp_t                    mem_rsp_i
);
    import soc_pkg::*;

    localparam int unsigned IDX_W = $clog2(`SOC_NUM_REQ);

    arb_state_e       state_q;
    logic [IDX_W-1:0] grant_q;
    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] ptr_next;
    logic [IDX_W-1:0] pick;
    logic             pick_valid;
    req_vec_t         pending;

    // ################################################
    // Request selection
    // ################################################

    always_comb begin : pending_vec
        for (int unsigned i = 0; i < `SOC_NUM_REQ; i++) begin
            pending[i] = req_i[i].cyc & req_i[i].stb;
        end
    end

    // First pending requester at or after the pointer
    always_comb begin : rr_pick
        int unsigned idx;
        pick       = ptr_q;
        pick_valid = 1'b0;
        for (int unsigned k = 0; k < `SOC_NUM_REQ; k++) begin
            idx = (32'(ptr_q) + k) % `SOC_NUM_REQ;
            if (pending[idx] && !pick_valid) begin
                pick       = IDX_W'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    // Pointer moves one past the port just served
    assign ptr_next = (grant_q == IDX_W'(`SOC_NUM_REQ - 1)) ? '0 : grant_q + 1'b1;

    // ################################################
    // Grant FSM
    // ################################################

    always_ff @(posedge clk_i) begin : arb_fsm
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
            ptr_q   <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        grant_q <= pick;
                        state_q <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    // One transfer per grant
                    if (mem_rsp_i.ack) begin
                        state_q <= ARB_IDLE;
                        ptr_q   <= ptr_next;
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    // ################################################
    // Forward and return paths
    // ################################################

    // Memory sees nothing while idle
    assign mem_req_o = (state_q == ARB_BUSY) ? req_i[grant_q] : '0;

    always_comb begin : rsp_route
        for (int unsigned i = 0; i < `SOC_NUM_REQ; i++) begin
            rsp_o[i].ack = (state_q == ARB_BUSY) && (grant_q == IDX_W'(i)) && mem_rsp_i.ack;
            rsp_o[i].dat = (grant_q == IDX_W'(i)) ? mem_rsp_i.dat : '0;
        end
    end

endmodule

// File: dummy_mem.sv
// ################################################
// Wishbone word memory, byte selects, 1-cycle ack
// ################################################

`timescale 1ns/1ns

`include "soc_defs.svh"

module dummy_mem (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  soc_pkg::wb_req_t wb_req_i,
    output soc_pkg::wb_rsp_t wb_rsp_o
);
    import soc_pkg::*;

    localparam int unsigned OFF_W = $clog2(`SOC_DATA_W / 8);
    localparam int unsigned IDX_W = $clog2(`SOC_MEM_WORDS);

    data_t            mem_q [`SOC_MEM_WORDS];
    data_t            rdat_q;
    logic             ack_q;
    logic [IDX_W-1:0] word_idx;
    logic             access;

    // Word part of the byte address
    assign word_idx = wb_req_i.adr[OFF_W +: IDX_W];

    // Accept a new access only while ack is low
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    always_ff @(posedge clk_i) begin : ack_reg
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Storage, cleared at reset
    always_ff @(posedge clk_i) begin : mem_write
        if (!rst_n_i) begin
            for (int unsigned w = 0; w < `SOC_MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (access && wb_req_i.we) begin
            for (int unsigned b = 0; b < `SOC_DATA_W / 8; b++) begin
                if (wb_req_i.sel[b]) begin
                    mem_q[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk_i) begin : mem_read
        if (access) begin
            rdat_q <= mem_q[word_idx];
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdat_q;

endmodule

// File: cluster_scheduler.sv
// ################################################
// Warp allocation to the first free cluster and
// round-robin merge of thread-block completions
// ################################################

`timescale 1ns/1ns

`include "soc_defs.svh"

module cluster_scheduler (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,

    // Allocation from control side
    input  logic                                           alloc_valid_i,
    input  soc_pkg::alloc_t                                alloc_i,
    output logic                                           alloc_ready_o,

    // Allocation towards clusters
    input  soc_pkg::cluster_vec_t                          cl_free_i,
    output soc_pkg::cluster_vec_t                          cl_alloc_o,
    output soc_pkg::alloc_t                                cl_alloc_data_o,

    // Completions from clusters
    input  soc_pkg::cluster_vec_t                          cl_done_i,
    input  soc_pkg::tgroup_id_t [`SOC_NUM_CLUSTERS-1:0]    cl_done_id_i,
    output soc_pkg::cluster_vec_t                          cl_done_ready_o,

    // Merged completion stream
    output logic                                           done_valid_o,
    output soc_pkg::tgroup_id_t                            done_id_o,
    input  logic                                           done_ready_i
);
    import soc_pkg::*;

    localparam int unsigned CL_IDX_W = $clog2(`SOC_NUM_CLUSTERS);

    logic [CL_IDX_W-1:0] ptr_q;
    logic [CL_IDX_W-1:0] sel;
    cluster_vec_t        first_free;

    // ################################################
    // Allocation
    // ################################################

    assign alloc_ready_o = |cl_free_i;

    // Lowest free cluster only
    always_comb begin : pick_free
        logic found;
        found      = 1'b0;
        first_free = '0;
        for (int unsigned i = 0; i < `SOC_NUM_CLUSTERS; i++) begin
            if (cl_free_i[i] && !found) begin
                first_free[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    assign cl_alloc_o      = alloc_valid_i ? first_free : '0;
    assign cl_alloc_data_o = alloc_i;

    // ################################################
    // Completion merge
    // ################################################

    // First done cluster at or after the pointer
    always_comb begin : pick_done
        int unsigned idx;
        logic        hit;
        hit = 1'b0;
        sel = ptr_q;
        for (int unsigned k = 0; k < `SOC_NUM_CLUSTERS; k++) begin
            idx = (32'(ptr_q) + k) % `SOC_NUM_CLUSTERS;
            if (cl_done_i[idx] && !hit) begin
                sel = CL_IDX_W'(idx);
                hit = 1'b1;
            end
        end
    end

    assign done_valid_o = |cl_done_i;
    assign done_id_o    = cl_done_id_i[sel];

    always_comb begin : done_ready
        cl_done_ready_o = '0;
        if (done_valid_o && done_ready_i) begin
            cl_done_ready_o[sel] = 1'b1;
        end
    end

    // Advance past the served cluster on a handshake
    always_ff @(posedge clk_i) begin : rr_ptr
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (done_valid_o && done_ready_i) begin
            ptr_q <= (sel == CL_IDX_W'(`SOC_NUM_CLUSTERS - 1)) ? '0 : sel + 1'b1;
        end
    end

endmodule

// File: gpu_soc_top.sv
// ################################################
// GPU SoC top, memory arbiter, dummy memory and
// cluster scheduler
// ################################################

`timescale 1ns/1ns

`include "soc_defs.svh"

module gpu_soc_top (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    // Memory requesters
    input  soc_pkg::fetch_req_t                         fetch_req_i,
    output soc_pkg::wb_rsp_t                            fetch_rsp_o,
    input  soc_pkg::wb_req_t                            data_req_i,
    output soc_pkg::wb_rsp_t                            data_rsp_o,
    input  soc_pkg::wb_req_t                            ctrl_req_i,
    output soc_pkg::wb_rsp_t                            ctrl_rsp_o,

    // Warp allocation
    input  logic                                        alloc_valid_i,
    input  soc_pkg::alloc_t                             alloc_i,
    output logic                                        alloc_ready_o,
    output soc_pkg::cluster_vec_t                       cl_alloc_o,
    output soc_pkg::alloc_t                             cl_alloc_data_o,
    input  soc_pkg::cluster_vec_t                       cl_free_i,

    // Thread-block completion
    input  soc_pkg::cluster_vec_t                       cl_done_i,
    input  soc_pkg::tgroup_id_t [`SOC_NUM_CLUSTERS-1:0] cl_done_id_i,
    output soc_pkg::cluster_vec_t                       cl_done_ready_o,
    output logic                                        done_valid_o,
    output soc_pkg::tgroup_id_t                         done_id_o,
    input  logic                                        done_ready_i
);
    import soc_pkg::*;

    // Arbiter port order
    localparam int unsigned FETCH_PORT = 0;
    localparam int unsigned DATA_PORT  = 1;
    localparam int unsigned CTRL_PORT  = 2;

    wb_req_t                    fetch_wb;
    wb_req_t [`SOC_NUM_REQ-1:0] arb_req;
    wb_rsp_t [`SOC_NUM_REQ-1:0] arb_rsp;
    wb_req_t                    mem_req;
    wb_rsp_t                    mem_rsp;

    // ################################################
    // Memory path
    // ################################################

    // Fetch becomes a full-word read
    assign fetch_wb.cyc = fetch_req_i.cyc;
    assign fetch_wb.stb = fetch_req_i.stb;
    assign fetch_wb.we  = 1'b0;
    assign fetch_wb.adr = fetch_req_i.adr;
    assign fetch_wb.sel = '1;
    assign fetch_wb.dat = '0;

    assign arb_req[FETCH_PORT] = fetch_wb;
    assign arb_req[DATA_PORT]  = data_req_i;
    assign arb_req[CTRL_PORT]  = ctrl_req_i;

    assign fetch_rsp_o = arb_rsp[FETCH_PORT];
    assign data_rsp_o  = arb_rsp[DATA_PORT];
    assign ctrl_rsp_o  = arb_rsp[CTRL_PORT];

    mem_arbiter i_mem_arbiter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (arb_req),
        .rsp_o    (arb_rsp),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp)
    );

    dummy_mem i_dummy_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_req_i(mem_req),
        .wb_rsp_o(mem_rsp)
    );

    // ################################################
    // Work distribution
    // ################################################

    cluster_scheduler i_cluster_scheduler (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .alloc_valid_i  (alloc_valid_i),
        .alloc_i        (alloc_i),
        .alloc_ready_o  (alloc_ready_o),
        .cl_free_i      (cl_free_i),
        .cl_alloc_o     (cl_alloc_o),
        .cl_alloc_data_o(cl_alloc_data_o),
        .cl_done_i      (cl_done_i),
        .cl_done_id_i   (cl_done_id_i),
        .cl_done_ready_o(cl_done_ready_o),
        .done_valid_o   (done_valid_o),
        .done_id_o      (done_id_o),
        .done_ready_i   (done_ready_i)
    );

endmodule

// File: gpu_soc_assert.sv
// ################################################
// Concurrent checks on the GPU SoC top, bound into
// every instance of the top level
// ################################################

`timescale 1ns/1ns

`include "soc_defs.svh"

module gpu_soc_assert (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input soc_pkg::fetch_req_t   fetch_req_i,
    input soc_pkg::wb_rsp_t      fetch_rsp_i,
    input soc_pkg::wb_req_t      data_req_i,
    input soc_pkg::wb_rsp_t      data_rsp_i,
    input soc_pkg::wb_req_t      ctrl_req_i,
    input soc_pkg::wb_rsp_t      ctrl_rsp_i,
    input soc_pkg::cluster_vec_t cl_done_ready_i,
    input logic                  done_valid_i,
    input soc_pkg::tgroup_id_t   done_id_i,
    input logic                  done_ready_i
);
    import soc_pkg::*;

    // A grant costs three cycles, so one full round of requesters bounds the wait
    localparam int unsigned ACK_LIMIT = 3 * `SOC_NUM_REQ;

    req_vec_t    pend;
    req_vec_t    ack;
    int unsigned fail_cnt = 0;

    assign pend = {ctrl_req_i.cyc & ctrl_req_i.stb,
                   data_req_i.cyc & data_req_i.stb,
                   fetch_req_i.cyc & fetch_req_i.stb};
    assign ack  = {ctrl_rsp_i.ack, data_rsp_i.ack, fetch_rsp_i.ack};

    // ################################################
    // Reset and memory bus
    // ################################################

    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> (ack == '0) && !done_valid_i && (cl_done_ready_i == '0))
    else begin
        $error("Acks or completion outputs active right after reset");
        fail_cnt++;
    end

    single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(ack))
    else begin
        $error("More than one requester acked in the same cycle");
        fail_cnt++;
    end

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack & ~pend) == '0)
    else begin
        $error("Ack seen on a requester with no pending request");
        fail_cnt++;
    end

    for (genvar p = 0; p < `SOC_NUM_REQ; p++) begin : g_ack_time
        ack_in_time: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (pend[p] && !ack[p]) |-> ##[1:ACK_LIMIT] ack[p])
        else begin
            $error("Requester %0d waited too long for its ack", p);
            fail_cnt++;
        end
    end

    // ################################################
    // Completion stream
    // ################################################

    done_id_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (done_valid_i && !done_ready_i) |=> $stable(done_id_i))
    else begin
        $error("Completion ID changed while waiting for acceptance");
        fail_cnt++;
    end

endmodule

bind gpu_soc_top gpu_soc_assert i_gpu_soc_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_rsp_i    (fetch_rsp_o),
    .data_req_i     (data_req_i),
    .data_rsp_i     (data_rsp_o),
    .ctrl_req_i     (ctrl_req_i),
    .ctrl_rsp_i     (ctrl_rsp_o),
    .cl_done_ready_i(cl_done_ready_o),
    .done_valid_i   (done_valid_o),
    .done_id_i      (done_id_o),
    .done_ready_i   (done_ready_i)
);

// File: tb_gpu_soc.sv
// ################################################
// Testbench for the GPU SoC top covering memory
// traffic, warp allocation and completion merge
// ################################################

`timescale 1ns/1ns

`include "soc_defs.svh"

module tb_gpu_soc;
    import soc_pkg::*;

    // All tests together need a few hundred cycles
    localparam int unsigned MAX_CYCLES = 4000;
    localparam int unsigned NUM_WORDS  = 8;
    localparam int unsigned BYTES      = `SOC_DATA_W / 8;
    localparam int unsigned NCL        = `SOC_NUM_CLUSTERS;

    logic                        clk_i;
    logic                        rst_n_i;
    fetch_req_t                  fetch_req_i;
    wb_rsp_t                     fetch_rsp_o;
    wb_req_t                     data_req_i;
    wb_rsp_t                     data_rsp_o;
    wb_req_t                     ctrl_req_i;
    wb_rsp_t                     ctrl_rsp_o;
    logic                        alloc_valid_i;
    alloc_t                      alloc_i;
    logic                        alloc_ready_o;
    cluster_vec_t                cl_alloc_o;
    alloc_t                      cl_alloc_data_o;
    cluster_vec_t                cl_free_i;
    cluster_vec_t                cl_done_i;
    tgroup_id_t [NCL-1:0]        cl_done_id_i;
    cluster_vec_t                cl_done_ready_o;
    logic                        done_valid_o;
    tgroup_id_t                  done_id_o;
    logic                        done_ready_i;

    // Reference memory that starts all zero
    data_t       ref_mem [`SOC_MEM_WORDS];
    addr_t       addrs [NUM_WORDS];
    int unsigned cycles;
    int unsigned checks;
    int unsigned errors;
    int unsigned test_err;
    int unsigned exp_port;
    logic        order_check;

    gpu_soc_top dut (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int unsigned total_errors();
        return errors + dut.i_gpu_soc_assert.fail_cnt;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s expected %h, observed %h", $time, what, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished, %0d errors", name, total_errors() - test_err);
        test_err = total_errors();
    endtask

    function automatic data_t merge(input data_t old, input data_t dat, input sel_t sel);
        data_t mask;
        for (int b = 0; b < BYTES; b++) begin
            mask[8*b +: 8] = {8{sel[b]}};
        end
        return (old & ~mask) | (dat & mask);
    endfunction

    function automatic wb_rsp_t port_rsp(input int unsigned p);
        case (p)
            0: return fetch_rsp_o;
            1: return data_rsp_o;
            default: return ctrl_rsp_o;
        endcase
    endfunction

    // Port 0 is fetch and takes only the read fields
    task automatic drive_port(input int unsigned p, input wb_req_t r);
        case (p)
            0: begin
                fetch_req_i.cyc <= r.cyc;
                fetch_req_i.stb <= r.stb;
                fetch_req_i.adr <= r.adr;
            end
            1: data_req_i <= r;
            default: ctrl_req_i <= r;
        endcase
    endtask

    // Request stays held after ack until the next access or a release
    task automatic bus_access(input int unsigned p, input logic we, input addr_t adr,
                              input sel_t sel, input data_t dat);
        wb_req_t r;
        wb_rsp_t rsp;
        r = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
        @(posedge clk_i);
        drive_port(p, r);
        do begin
            @(negedge clk_i);
            rsp = port_rsp(p);
        end while (!rsp.ack);
        if (we) begin
            ref_mem[adr / BYTES] = merge(ref_mem[adr / BYTES], dat, sel);
        end else begin
            check_value($sformatf("port %0d read at %h", p, adr), ref_mem[adr / BYTES], rsp.dat);
        end
    endtask

    task automatic release_port(input int unsigned p);
        @(posedge clk_i);
        drive_port(p, '0);
    endtask

    task automatic single_access(input int unsigned p, input logic we, input addr_t adr,
                                 input sel_t sel, input data_t dat);
        bus_access(p, we, adr, sel, dat);
        release_port(p);
    endtask

    task automatic read_burst(input int unsigned p);
        for (int i = 0; i < 4; i++) begin
            bus_access(p, 1'b0, addrs[(i + p) % NUM_WORDS], '1, '0);
        end
        release_port(p);
    endtask

    // Rotating-pointer model that moves one past every acked port
    always @(negedge clk_i) begin : ack_order
        wb_rsp_t rsp;
        for (int unsigned p = 0; p < `SOC_NUM_REQ; p++) begin
            rsp = port_rsp(p);
            if (rst_n_i && rsp.ack) begin
                if (order_check) begin
                    check_value("ack order", exp_port, p);
                end
                exp_port = (p + 1) % `SOC_NUM_REQ;
            end
        end
    end

    initial begin : main
        cluster_vec_t low_free;
        cluster_vec_t served;
        int unsigned  last_cl;
        int unsigned  exp_cl;
        int unsigned  hs;
        int unsigned  base;
        void'($urandom(68));
        checks      = 0;
        errors      = 0;
        test_err    = 0;
        exp_port    = 0;
        order_check = 1'b0;
        for (int w = 0; w < `SOC_MEM_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        rst_n_i       <= 1'b0;
        fetch_req_i   <= '0;
        data_req_i    <= '0;
        ctrl_req_i    <= '0;
        alloc_valid_i <= 1'b0;
        alloc_i       <= '0;
        cl_free_i     <= '0;
        cl_done_i     <= '0;
        cl_done_id_i  <= '0;
        done_ready_i  <= 1'b0;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        end_test("reset");

        // Full words written through data and control and read back on every port
        for (int i = 0; i < NUM_WORDS; i++) begin
            addrs[i] = addr_t'($urandom_range(0, `SOC_MEM_WORDS - 1) * BYTES);
            single_access(1 + i % 2, 1'b1, addrs[i], '1, $urandom);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            for (int unsigned p = 0; p < `SOC_NUM_REQ; p++) begin
                single_access(p, 1'b0, addrs[i], '1, '0);
            end
        end
        end_test("write_read");

        // Partial writes read back on fetch and control with control last
        for (int i = 0; i < 6; i++) begin
            single_access(1 + i % 2, 1'b1, addrs[i], sel_t'($urandom), $urandom);
        end
        for (int i = 0; i < 6; i++) begin
            single_access((i % 2) ? 2 : 0, 1'b0, addrs[i], '1, '0);
        end
        end_test("byte_select");

        // All three ports back to back with grants rotating from fetch
        order_check = 1'b1;
        fork
            read_burst(0);
            read_burst(1);
            read_burst(2);
        join
        order_check = 1'b0;
        end_test("contention");

        for (int i = 0; i < 24; i++) begin
            @(posedge clk_i);
            alloc_valid_i <= 1'($urandom);
            alloc_i       <= alloc_t'({$urandom, $urandom});
            cl_free_i     <= cluster_vec_t'($urandom);
            @(negedge clk_i);
            low_free = cl_free_i & cluster_vec_t'(~cl_free_i + 1'b1);
            check_value("alloc ready", cl_free_i != '0, alloc_ready_o);
            check_value("alloc target", alloc_valid_i ? low_free : '0, cl_alloc_o);
            check_value("alloc data", alloc_i, cl_alloc_data_o);
        end
        @(posedge clk_i);
        alloc_valid_i <= 1'b0;
        end_test("allocation");

        // Distinct IDs whose low bits are the cluster number
        base = $urandom;
        @(posedge clk_i);
        for (int c = 0; c < NCL; c++) begin
            cl_done_id_i[c] <= tgroup_id_t'(base * NCL + c);
        end
        cl_done_i <= '1;
        last_cl = NCL - 1;
        served  = '0;
        hs      = 0;
        for (int i = 0; i < 48; i++) begin
            @(posedge clk_i);
            done_ready_i <= 1'($urandom);
            @(negedge clk_i);
            check_value("done valid", 1'b1, done_valid_o);
            if (done_ready_i) begin
                exp_cl = (last_cl + 1) % NCL;
                check_value("done id", cl_done_id_i[exp_cl], done_id_o);
                check_value("done ready", 1 << exp_cl, cl_done_ready_o);
                last_cl = exp_cl;
                served  = served | cl_done_ready_o;
                hs++;
                if (hs % NCL == 0) begin
                    check_value("clusters served", cluster_vec_t'('1), served);
                    served = '0;
                end
            end else begin
                check_value("done ready idle", '0, cl_done_ready_o);
            end
        end
        @(posedge clk_i);
        cl_done_i    <= '0;
        done_ready_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        end_test("completion");

        $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, dut.i_gpu_soc_assert.fail_cnt);
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
soc_pkg.sv
mem_arbiter.sv
dummy_mem.sv
cluster_scheduler.sv
gpu_soc_top.sv
gpu_soc_assert.sv
tb_gpu_soc.sv

// File: Bender.yml
package:
  name: gpu_soc

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - mem_arbiter.sv
      - dummy_mem.sv
      - cluster_scheduler.sv
      - gpu_soc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - gpu_soc_assert.sv
      - tb_gpu_soc.sv
